// File: common/xv_bus_pkg.sv
// bus side definitions for the CPU registers, XR space and interrupt sources
package xv_bus_pkg;

typedef logic [7:0]  byte_t;        // cpu bus byte
typedef logic [15:0] word_t;        // register and vram word
typedef logic [3:0]  reg_num_t;     // cpu register number
typedef logic [4:0]  xr_addr_t;     // XR register address
typedef logic [1:0]  intr_t;        // one bit per interrupt source

// CPU register numbers, even byte is the high byte
localparam reg_num_t XM_INT_CTRL = 4'h0;    // even: mask, odd: status / clear
localparam reg_num_t XM_XR_ADDR  = 4'h1;    // XR address for XR_DATA
localparam reg_num_t XM_XR_DATA  = 4'h2;    // odd byte commits XR write
localparam reg_num_t XM_WR_ADDR  = 4'h3;    // vram write address
localparam reg_num_t XM_DATA     = 4'h4;    // odd write commits, read gives buffer
localparam reg_num_t XM_RD_ADDR  = 4'h5;    // odd write starts vram read

// XR space
localparam xr_addr_t XR_PALETTE  = 5'h00;   // 16 palette entries 0x00-0x0F
localparam xr_addr_t XR_VID_INTR = 5'h10;   // data bit 0 raises video interrupt

// interrupt bit positions
localparam int INTR_VIDEO = 0;              // software triggered via XR
localparam int INTR_VSYNC = 1;              // start of vertical sync

endpackage

// File: common/xv_video_pkg.sv
// video side definitions for timing defaults, vram addressing and colour
package xv_video_pkg;

typedef logic [11:0] addr_t;        // vram word address
typedef logic [3:0]  color_t;       // palette index
typedef logic [11:0] rgb_t;         // 4 bits each of red, green, blue
typedef logic [7:0]  hres_t;        // pixel counter
typedef logic [7:0]  vres_t;        // line counter

localparam int VRAM_WORDS   = 4096;
localparam int PIX_PER_WORD = 4;    // one nibble per pixel

// horizontal timing in pixels, 24 total
localparam int H_VISIBLE = 16;
localparam int H_FRONT   = 2;
localparam int H_SYNC    = 2;
localparam int H_BACK    = 4;

// vertical timing in lines, 12 total
localparam int V_VISIBLE = 8;
localparam int V_FRONT   = 1;
localparam int V_SYNC    = 1;
localparam int V_BACK    = 2;

endpackage

// File: rtl/intr_ctrl.sv
// interrupt pending status, masking and one cycle bus interrupt pulse
`default_nettype none
`timescale 1ns/1ps

module intr_ctrl
    import xv_bus_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire intr_t  intr_trigger_i,     // one cycle per source
    input  wire intr_t  intr_mask_i,        // 1 enables bus interrupt
    input  wire intr_t  intr_clear_i,       // 1 clears pending
    output intr_t       intr_status_o,
    output logic        bus_intr_o
);

always_ff @(posedge clk) begin
    if (reset_i) begin
        intr_status_o <= '0;
        bus_intr_o    <= 1'b0;
    end else begin
        // only new unmasked sources interrupt
        bus_intr_o    <= |(intr_trigger_i & intr_mask_i & ~intr_status_o);
        intr_status_o <= (intr_status_o | intr_trigger_i) & ~intr_clear_i;
    end
end

endmodule
`default_nettype wire

// File: rtl/vram_arb.sv
// video RAM with video read priority and select/ack access for the register interface
`default_nettype none
`timescale 1ns/1ps

module vram_arb
    import xv_bus_pkg::*, xv_video_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   vgen_sel_i,         // always wins
    input  wire addr_t  vgen_addr_i,
    input  wire logic   regs_sel_i,         // held until ack
    input  wire logic   regs_wr_i,
    input  wire addr_t  regs_addr_i,
    input  wire word_t  regs_data_i,
    output word_t       vram_data_o,        // read data, one cycle latency
    output logic        regs_ack_o
);

word_t  mem [VRAM_WORDS];
logic   regs_go;            // register access served this cycle
addr_t  rd_addr;

// no second service while the ack is still out
assign regs_go = regs_sel_i && !vgen_sel_i && !regs_ack_o;
assign rd_addr = vgen_sel_i ? vgen_addr_i : regs_addr_i;

always_ff @(posedge clk) begin
    if (regs_go && regs_wr_i) begin
        mem[regs_addr_i] <= regs_data_i;
    end
    vram_data_o <= mem[rd_addr];        // old data on same-address write
    regs_ack_o  <= regs_go;
end

endmodule
`default_nettype wire

// File: regs/reg_interface.sv
// CPU register interface turning byte accesses into vram, XR and interrupt control
`default_nettype none
`timescale 1ns/1ps

module reg_interface
    import xv_bus_pkg::*, xv_video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       bus_write_strobe_i,
    input  wire logic       bus_read_strobe_i,
    input  wire reg_num_t   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,      // 1 = odd byte, commits words
    input  wire byte_t      bus_data_i,
    output byte_t           bus_data_o,
    output logic            bus_ack_o,
    input  wire logic       vram_ack_i,         // one cycle, read data valid with it
    input  wire word_t      vram_data_i,
    input  wire intr_t      intr_status_i,
    output logic            vram_sel_o,         // held until ack
    output logic            vram_wr_o,
    output addr_t           vram_addr_o,
    output word_t           vram_data_o,
    output logic            xr_wr_o,
    output xr_addr_t        xr_addr_o,
    output word_t           xr_data_o,
    output logic            video_intr_o,       // software interrupt trigger
    output intr_t           intr_mask_o,
    output intr_t           intr_clear_o
);

typedef enum logic [1:0] {
    IDLE,                   // waiting for a strobe
    VRAM_WAIT,              // select held for arbiter
    ACK                     // bus ack cycle
} state_t;

state_t     state;
byte_t      even_byte;      // latched high byte
word_t      wr_word;
word_t      rd_word;
word_t      rd_buffer;      // result of last RD_ADDR read
addr_t      wr_addr;
logic       wr_odd;

assign wr_word   = {even_byte, bus_data_i};
assign wr_odd    = (state == IDLE) && bus_write_strobe_i && bus_bytesel_i;
assign bus_ack_o = (state == ACK);

// readable registers
always_comb begin
    case (bus_reg_num_i)
        XM_INT_CTRL: rd_word = {byte_t'(intr_mask_o), byte_t'(intr_status_i)};
        XM_XR_ADDR:  rd_word = word_t'(xr_addr_o);
        XM_WR_ADDR:  rd_word = word_t'(wr_addr);
        XM_DATA:     rd_word = rd_buffer;
        default:     rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state        <= IDLE;
        vram_sel_o   <= 1'b0;
        xr_wr_o      <= 1'b0;
        video_intr_o <= 1'b0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
        xr_addr_o    <= '0;
        wr_addr      <= '0;
    end else begin
        xr_wr_o      <= 1'b0;       // strobes last one cycle
        video_intr_o <= 1'b0;
        intr_clear_o <= '0;
        case (state)
            IDLE: begin
                if (bus_write_strobe_i || bus_read_strobe_i) begin
                    state <= ACK;   // register access, ack next cycle
                end
                if (bus_write_strobe_i && !bus_bytesel_i && bus_reg_num_i == XM_INT_CTRL) begin
                    intr_mask_o <= intr_t'(bus_data_i);
                end
                if (wr_odd) begin
                    case (bus_reg_num_i)
                        XM_INT_CTRL: intr_clear_o <= intr_t'(bus_data_i); // 1 clears
                        XM_XR_ADDR:  xr_addr_o <= xr_addr_t'(wr_word);
                        XM_XR_DATA: begin
                            xr_wr_o      <= 1'b1;
                            video_intr_o <= (xr_addr_o == XR_VID_INTR) && bus_data_i[0];
                        end
                        XM_WR_ADDR:  wr_addr <= addr_t'(wr_word);
                        XM_DATA: begin
                            vram_sel_o <= 1'b1;
                            wr_addr    <= wr_addr + 1'b1;   // auto increment
                            state      <= VRAM_WAIT;
                        end
                        XM_RD_ADDR: begin
                            vram_sel_o <= 1'b1;
                            state      <= VRAM_WAIT;
                        end
                        default: ;
                    endcase
                end
            end
            VRAM_WAIT: begin
                if (vram_ack_i) begin
                    vram_sel_o <= 1'b0;
                    state      <= ACK;  // bus ack one cycle after arbiter
                end
            end
            default: state <= IDLE;
        endcase
    end
end

// data path, loaded as the access starts
always_ff @(posedge clk) begin
    if (state == IDLE && bus_write_strobe_i) begin
        if (!bus_bytesel_i) begin
            even_byte <= bus_data_i;
        end
        if (wr_odd && bus_reg_num_i == XM_XR_DATA) begin
            xr_data_o <= wr_word;
        end
        if (wr_odd && bus_reg_num_i == XM_DATA) begin
            vram_addr_o <= wr_addr;     // pre-increment address
            vram_data_o <= wr_word;
            vram_wr_o   <= 1'b1;
        end
        if (wr_odd && bus_reg_num_i == XM_RD_ADDR) begin
            vram_addr_o <= addr_t'(wr_word);
            vram_wr_o   <= 1'b0;
        end
    end
    if (state == IDLE && bus_read_strobe_i) begin
        bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
    end
    if (state == VRAM_WAIT && vram_ack_i && !vram_wr_o) begin
        rd_buffer <= vram_data_i;
    end
end

endmodule
`default_nettype wire

// File: video/video_gen.sv
// video timing counters, sync and enable, and colour index fetch from vram
`default_nettype none
`timescale 1ns/1ps

module video_gen
    import xv_bus_pkg::*, xv_video_pkg::*;
#(
    parameter int H_VISIBLE = xv_video_pkg::H_VISIBLE,  // multiple of 4
    parameter int H_FRONT   = xv_video_pkg::H_FRONT,
    parameter int H_SYNC    = xv_video_pkg::H_SYNC,
    parameter int H_BACK    = xv_video_pkg::H_BACK,
    parameter int V_VISIBLE = xv_video_pkg::V_VISIBLE,
    parameter int V_FRONT   = xv_video_pkg::V_FRONT,
    parameter int V_SYNC    = xv_video_pkg::V_SYNC,
    parameter int V_BACK    = xv_video_pkg::V_BACK
) (
    input  wire logic   clk,
    input  wire logic   reset_i,
    input  wire word_t  vram_data_i,        // valid cycle after select
    output logic        vram_sel_o,         // one cycle read, always served
    output addr_t       vram_addr_o,
    output color_t      color_index_o,
    output logic        hsync_o,            // active high
    output logic        vsync_o,
    output logic        dv_de_o,
    output logic        vsync_intr_o        // first cycle of vsync
);

localparam int H_TOTAL        = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
localparam int V_TOTAL        = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int WORDS_PER_LINE = H_VISIBLE / PIX_PER_WORD;

localparam hres_t H_VIS_END  = hres_t'(H_VISIBLE);
localparam hres_t H_SYNC_BEG = hres_t'(H_VISIBLE + H_FRONT);
localparam hres_t H_SYNC_END = hres_t'(H_VISIBLE + H_FRONT + H_SYNC);
localparam hres_t H_LAST     = hres_t'(H_TOTAL - 1);
localparam vres_t V_VIS_END  = vres_t'(V_VISIBLE);
localparam vres_t V_SYNC_BEG = vres_t'(V_VISIBLE + V_FRONT);
localparam vres_t V_SYNC_END = vres_t'(V_VISIBLE + V_FRONT + V_SYNC);
localparam vres_t V_LAST     = vres_t'(V_TOTAL - 1);

hres_t  h_count;
vres_t  v_count;
vres_t  v_next;
logic   line_end;
logic   grp_fetch;          // next group on this line
logic   eol_fetch;          // first group of next line
vres_t  fetch_line;
hres_t  fetch_group;
word_t  pix_word;           // remaining nibbles of current group

assign line_end    = (h_count == H_LAST);
assign v_next      = (v_count == V_LAST) ? '0 : v_count + 1'b1;
assign grp_fetch   = (v_count < V_VIS_END) && (h_count[1:0] == 2'd3)
                   && (h_count < H_VIS_END - 1'b1);
assign eol_fetch   = line_end && (v_next < V_VIS_END);
assign fetch_line  = eol_fetch ? v_next : v_count;
assign fetch_group = eol_fetch ? '0 : (h_count >> 2) + 1'b1;
assign vram_sel_o  = grp_fetch || eol_fetch;
assign vram_addr_o = addr_t'(int'(fetch_line) * WORDS_PER_LINE + int'(fetch_group));

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count      <= '0;     // top-left visible pixel
        v_count      <= '0;
        hsync_o      <= 1'b0;
        vsync_o      <= 1'b0;
        dv_de_o      <= 1'b0;
        vsync_intr_o <= 1'b0;
    end else begin
        h_count <= line_end ? '0 : h_count + 1'b1;
        if (line_end) begin
            v_count <= v_next;
        end
        dv_de_o      <= (h_count < H_VIS_END) && (v_count < V_VIS_END);
        hsync_o      <= (h_count >= H_SYNC_BEG) && (h_count < H_SYNC_END);
        vsync_o      <= (v_count >= V_SYNC_BEG) && (v_count < V_SYNC_END);
        vsync_intr_o <= (h_count == '0) && (v_count == V_SYNC_BEG);
    end
end

// nibbles high to low, group word arrives on phase 0
always_ff @(posedge clk) begin
    if (h_count[1:0] == 2'd0) begin
        color_index_o <= vram_data_i[15:12];
        pix_word      <= {vram_data_i[11:0], 4'h0};
    end else begin
        color_index_o <= pix_word[15:12];
        pix_word      <= {pix_word[11:0], 4'h0};
    end
end

endmodule
`default_nettype wire

// File: video/color_out.sv
// palette lookup with sync and display enable delayed to match the RGB output
`default_nettype none
`timescale 1ns/1ps

module color_out
    import xv_bus_pkg::*, xv_video_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset_i,
    input  wire logic       xr_wr_i,
    input  wire xr_addr_t   xr_addr_i,
    input  wire word_t      xr_data_i,      // low 12 bits are RGB
    input  wire color_t     color_index_i,
    input  wire logic       hsync_i,
    input  wire logic       vsync_i,
    input  wire logic       dv_de_i,
    output logic [3:0]      red_o,
    output logic [3:0]      green_o,
    output logic [3:0]      blue_o,
    output logic            hsync_o,        // 2 cycles after inputs
    output logic            vsync_o,
    output logic            dv_de_o
);

rgb_t   palette [16];
rgb_t   lookup_rgb;         // stage 1 result
logic   hsync_1;
logic   vsync_1;
logic   dv_de_1;

// palette writes and registered lookup
always_ff @(posedge clk) begin
    if (xr_wr_i && xr_addr_i < XR_VID_INTR) begin
        palette[color_t'(xr_addr_i - XR_PALETTE)] <= xr_data_i[11:0];
    end
    lookup_rgb <= palette[color_index_i];
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        {hsync_1, vsync_1, dv_de_1}   <= 3'b000;
        {hsync_o, vsync_o, dv_de_o}   <= 3'b000;
        {red_o, green_o, blue_o}      <= '0;
    end else begin
        {hsync_1, vsync_1, dv_de_1}   <= {hsync_i, vsync_i, dv_de_i};
        {hsync_o, vsync_o, dv_de_o}   <= {hsync_1, vsync_1, dv_de_1};
        {red_o, green_o, blue_o}      <= dv_de_1 ? lookup_rgb : '0; // black in blanking
    end
end

endmodule
`default_nettype wire

// File: rtl/xosera_main.sv
// display controller top level joining register interface, vram, video and interrupts
`default_nettype none
`timescale 1ns/1ps

module xosera_main
    import xv_bus_pkg::*, xv_video_pkg::*;
#(
    parameter int H_VISIBLE = xv_video_pkg::H_VISIBLE,
    parameter int H_FRONT   = xv_video_pkg::H_FRONT,
    parameter int H_SYNC    = xv_video_pkg::H_SYNC,
    parameter int H_BACK    = xv_video_pkg::H_BACK,
    parameter int V_VISIBLE = xv_video_pkg::V_VISIBLE,
    parameter int V_FRONT   = xv_video_pkg::V_FRONT,
    parameter int V_SYNC    = xv_video_pkg::V_SYNC,
    parameter int V_BACK    = xv_video_pkg::V_BACK
) (
    input  wire logic       clk,                // pixel clock
    input  wire logic       reset_i,
    input  wire logic       bus_write_strobe_i, // one cycle write strobe
    input  wire logic       bus_read_strobe_i,  // one cycle read strobe
    input  wire reg_num_t   bus_reg_num_i,
    input  wire logic       bus_bytesel_i,      // 0 even (high), 1 odd (low)
    input  wire byte_t      bus_data_i,
    output byte_t           bus_data_o,         // valid with ack
    output logic            bus_ack_o,
    output logic            bus_intr_o,         // one cycle interrupt pulse
    output logic [3:0]      red_o,
    output logic [3:0]      green_o,
    output logic [3:0]      blue_o,
    output logic            hsync_o,
    output logic            vsync_o,
    output logic            dv_de_o             // display enable
);

// vram paths
logic       vgen_vram_sel;
addr_t      vgen_vram_addr;
word_t      vram_data;          // shared read data, video and regs
logic       regs_vram_sel;
logic       regs_vram_ack;
logic       regs_vram_wr;
addr_t      regs_vram_addr;
word_t      regs_vram_data;

// XR write bus
logic       xr_wr;
xr_addr_t   xr_addr;
word_t      xr_data;

// video gen to colour stage
color_t     color_index;
logic       vgen_hsync;
logic       vgen_vsync;
logic       vgen_dv_de;

// interrupts
intr_t      intr_trigger;
intr_t      intr_mask;
intr_t      intr_clear;
intr_t      intr_status;

reg_interface u_regs (
    .clk(clk), .reset_i(reset_i),
    .bus_write_strobe_i(bus_write_strobe_i), .bus_read_strobe_i(bus_read_strobe_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i), .bus_data_o(bus_data_o), .bus_ack_o(bus_ack_o),
    .vram_ack_i(regs_vram_ack), .vram_data_i(vram_data),
    .intr_status_i(intr_status),
    .vram_sel_o(regs_vram_sel), .vram_wr_o(regs_vram_wr),
    .vram_addr_o(regs_vram_addr), .vram_data_o(regs_vram_data),
    .xr_wr_o(xr_wr), .xr_addr_o(xr_addr), .xr_data_o(xr_data),
    .video_intr_o(intr_trigger[INTR_VIDEO]),    // XR_VID_INTR write
    .intr_mask_o(intr_mask), .intr_clear_o(intr_clear)
);

video_gen #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) u_vgen (
    .clk(clk), .reset_i(reset_i),
    .vram_data_i(vram_data),
    .vram_sel_o(vgen_vram_sel), .vram_addr_o(vgen_vram_addr),
    .color_index_o(color_index),
    .hsync_o(vgen_hsync), .vsync_o(vgen_vsync), .dv_de_o(vgen_dv_de),
    .vsync_intr_o(intr_trigger[INTR_VSYNC])     // first cycle of vsync
);

vram_arb u_vram (
    .clk(clk),
    .vgen_sel_i(vgen_vram_sel), .vgen_addr_i(vgen_vram_addr),
    .regs_sel_i(regs_vram_sel), .regs_wr_i(regs_vram_wr),
    .regs_addr_i(regs_vram_addr), .regs_data_i(regs_vram_data),
    .vram_data_o(vram_data), .regs_ack_o(regs_vram_ack)
);

color_out u_color (
    .clk(clk), .reset_i(reset_i),
    .xr_wr_i(xr_wr), .xr_addr_i(xr_addr), .xr_data_i(xr_data),
    .color_index_i(color_index),
    .hsync_i(vgen_hsync), .vsync_i(vgen_vsync), .dv_de_i(vgen_dv_de),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

intr_ctrl u_intr (
    .clk(clk), .reset_i(reset_i),
    .intr_trigger_i(intr_trigger), .intr_mask_i(intr_mask), .intr_clear_i(intr_clear),
    .intr_status_o(intr_status), .bus_intr_o(bus_intr_o)
);

endmodule
`default_nettype wire

// File: tb/xosera_tb.sv
// testbench for the display controller top level covering bus, vram, interrupts and pixels
`timescale 1ns/1ps

module xosera_tb
    import xv_bus_pkg::*, xv_video_pkg::*;
();

localparam int FRAME_CYCLES = (H_VISIBLE + H_FRONT + H_SYNC + H_BACK)
                            * (V_VISIBLE + V_FRONT + V_SYNC + V_BACK);
localparam int FRAME_LINES  = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
localparam int RUN_LIMIT    = 20 * FRAME_CYCLES;    // whole run incl. several frames
localparam int ACK_LIMIT    = 64;
localparam int NUM_ROWS     = 6;
localparam int LINE_WORDS   = H_VISIBLE / PIX_PER_WORD;

logic       clk                = 1'b0;
logic       reset_i            = 1'b1;
logic       bus_write_strobe_i = 1'b0;
logic       bus_read_strobe_i  = 1'b0;
reg_num_t   bus_reg_num_i      = '0;
logic       bus_bytesel_i      = 1'b0;
byte_t      bus_data_i         = '0;
byte_t      bus_data_o;
logic       bus_ack_o, bus_intr_o, hsync_o, vsync_o, dv_de_o;
logic [3:0] red_o, green_o, blue_o;

// stimulus table where row 3 has no address write and relies on auto increment
addr_t      tbl_addr [NUM_ROWS] = '{12'h100, 12'h7ff, 12'h800, 12'h801, 12'hfff, 12'h020};
logic       tbl_set  [NUM_ROWS] = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
word_t      tbl_data [NUM_ROWS];
rgb_t       pal_data [16];
word_t      line_data [LINE_WORDS];     // vram words of line 0
integer     seed        = 83446;
int         cycle_count = 0;
int         intr_count  = 0;            // bus_intr_o pulses seen

xosera_main #(
    .H_VISIBLE(H_VISIBLE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_VISIBLE(V_VISIBLE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
) u_dut (
    .clk(clk), .reset_i(reset_i),
    .bus_write_strobe_i(bus_write_strobe_i), .bus_read_strobe_i(bus_read_strobe_i),
    .bus_reg_num_i(bus_reg_num_i), .bus_bytesel_i(bus_bytesel_i), .bus_data_i(bus_data_i),
    .bus_data_o(bus_data_o), .bus_ack_o(bus_ack_o), .bus_intr_o(bus_intr_o),
    .red_o(red_o), .green_o(green_o), .blue_o(blue_o),
    .hsync_o(hsync_o), .vsync_o(vsync_o), .dv_de_o(dv_de_o)
);

always #4 clk = ~clk;   // 8 ns period

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (bus_intr_o) begin
        intr_count <= intr_count + 1;
    end
    if (cycle_count >= RUN_LIMIT) begin
        $display("run did not finish within %0d cycles", RUN_LIMIT);
        $display("Errors found");
        $fatal(1);
    end
end

task automatic check(input logic ok, input string msg);
    assert (ok) else begin
        $display("error at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1);
    end
endtask

task automatic wait_ack(input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!bus_ack_o) begin
        n++;
        if (n >= ACK_LIMIT) begin
            $display("no bus ack within %0d cycles for %s", ACK_LIMIT, what);
            $display("Errors found");
            $fatal(1);
        end
        @(negedge clk);
    end
endtask

task automatic bus_write(input reg_num_t reg_num, input logic bytesel, input byte_t data);
    @(posedge clk);
    bus_write_strobe_i <= 1'b1;     // one cycle strobe
    bus_reg_num_i      <= reg_num;
    bus_bytesel_i      <= bytesel;
    bus_data_i         <= data;
    @(posedge clk);
    bus_write_strobe_i <= 1'b0;
    wait_ack("a bus write");
endtask

task automatic bus_read(input reg_num_t reg_num, input logic bytesel, output byte_t data);
    @(posedge clk);
    bus_read_strobe_i <= 1'b1;
    bus_reg_num_i     <= reg_num;
    bus_bytesel_i     <= bytesel;
    @(posedge clk);
    bus_read_strobe_i <= 1'b0;
    wait_ack("a bus read");
    data = bus_data_o;              // valid in ack cycle
endtask

task automatic write_word(input reg_num_t reg_num, input word_t data);
    bus_write(reg_num, 1'b0, data[15:8]);   // even byte first
    bus_write(reg_num, 1'b1, data[7:0]);    // odd byte commits
endtask

task automatic read_word(input reg_num_t reg_num, output word_t data);
    byte_t hi;
    byte_t lo;
    bus_read(reg_num, 1'b0, hi);
    bus_read(reg_num, 1'b1, lo);
    data = {hi, lo};
endtask

// counts enable, hsync and interrupt cycles up to the next vsync_o rise
task automatic wait_vsync_rise(output int de_cycles, output int hs_cycles,
                               output int pulses, output logic intr_before);
    logic vs_prev;
    logic intr_prev;
    logic rose;
    int   n;
    de_cycles   = 0;
    hs_cycles   = 0;
    pulses      = 0;
    intr_before = 1'b0;
    intr_prev   = 1'b0;
    vs_prev     = vsync_o;
    rose        = 1'b0;
    n           = 0;
    while (!rose) begin
        @(negedge clk);
        n++;
        if (n > 2 * FRAME_CYCLES) begin
            $display("vsync_o did not rise within %0d cycles", 2 * FRAME_CYCLES);
            $display("Errors found");
            $fatal(1);
        end
        rose = vsync_o && !vs_prev;
        if (rose) begin
            intr_before = intr_prev;    // pulse one cycle ahead of the rise
        end
        if (dv_de_o) begin
            de_cycles++;
        end else begin
            check({red_o, green_o, blue_o} == 12'h000, "rgb not black with dv_de_o low");
        end
        if (hsync_o) begin
            hs_cycles++;
        end
        if (bus_intr_o) begin
            pulses++;
        end
        vs_prev   = vsync_o;
        intr_prev = bus_intr_o;
    end
endtask

// first visible line after vsync is line 0 with nibbles high to low
task automatic check_first_line();
    int     de_cycles;
    int     hs_cycles;
    int     pulses;
    logic   intr_before;
    int     k;
    int     n;
    word_t  w;
    color_t nib;
    wait_vsync_rise(de_cycles, hs_cycles, pulses, intr_before);
    k = 0;
    n = 0;
    while (k < H_VISIBLE) begin
        @(negedge clk);
        n++;
        if (n > FRAME_CYCLES) begin
            $display("display enable missing for line 0 pixels");
            $display("Errors found");
            $fatal(1);
        end
        if (dv_de_o) begin
            w   = line_data[k / PIX_PER_WORD];
            nib = color_t'(w >> (4 * (PIX_PER_WORD - 1 - k % PIX_PER_WORD)));
            check({red_o, green_o, blue_o} == pal_data[nib],
                  $sformatf("pixel %0d rgb %h, expected %h", k,
                            {red_o, green_o, blue_o}, pal_data[nib]));
            k++;
        end else begin
            check({red_o, green_o, blue_o} == 12'h000, "rgb not black with dv_de_o low");
        end
    end
endtask

initial begin
    byte_t  rd_byte;
    word_t  rd_data;
    int     count0;
    int     de_cycles;
    int     hs_cycles;
    int     pulses;
    logic   intr_before;

    for (int i = 0; i < NUM_ROWS; i++) tbl_data[i] = word_t'($random(seed));
    for (int i = 0; i < 16; i++) pal_data[i] = rgb_t'($random(seed));
    for (int i = 0; i < LINE_WORDS; i++) line_data[i] = word_t'($random(seed));

    // reset held for 4 cycles
    repeat (3) begin
        @(negedge clk);
        check(!bus_ack_o && !bus_intr_o && !hsync_o && !vsync_o && !dv_de_o,
              "outputs not low during reset");
    end
    @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check(!bus_ack_o && !bus_intr_o && !hsync_o && !vsync_o && !dv_de_o,
          "outputs not low after reset");
    read_word(XM_INT_CTRL, rd_data);
    check(rd_data == 16'h0000, $sformatf("mask/status %h after reset", rd_data));

    // vram round trip
    for (int i = 0; i < NUM_ROWS; i++) begin
        if (tbl_set[i]) begin
            write_word(XM_WR_ADDR, word_t'(tbl_addr[i]));
        end
        write_word(XM_DATA, tbl_data[i]);
        read_word(XM_WR_ADDR, rd_data);     // one past the written word
        check(rd_data == word_t'(addr_t'(tbl_addr[i] + 12'd1)),
              $sformatf("WR_ADDR %h after write to %h", rd_data, tbl_addr[i]));
    end
    for (int i = 0; i < NUM_ROWS; i++) begin
        write_word(XM_RD_ADDR, word_t'(tbl_addr[i]));
        read_word(XM_DATA, rd_data);
        check(rd_data == tbl_data[i],
              $sformatf("vram %h read %h, expected %h", tbl_addr[i], rd_data, tbl_data[i]));
    end

    // software interrupt through XR_VID_INTR
    bus_write(XM_INT_CTRL, 1'b0, byte_t'(1 << INTR_VIDEO));
    write_word(XM_XR_ADDR, word_t'(XR_VID_INTR));
    count0 = intr_count;
    write_word(XM_XR_DATA, 16'h0001);
    repeat (3) @(negedge clk);
    check(intr_count == count0 + 1, "no single bus_intr_o pulse for video trigger");
    bus_read(XM_INT_CTRL, 1'b1, rd_byte);
    check(rd_byte[INTR_VIDEO], "video status bit not set");
    write_word(XM_XR_DATA, 16'h0001);   // already pending
    repeat (3) @(negedge clk);
    check(intr_count == count0 + 1, "pulse from a trigger that was already pending");
    bus_write(XM_INT_CTRL, 1'b1, byte_t'(1 << INTR_VIDEO));
    bus_read(XM_INT_CTRL, 1'b1, rd_byte);
    check(!rd_byte[INTR_VIDEO], "video status bit not cleared");
    bus_write(XM_INT_CTRL, 1'b0, 8'h00);   // mask off
    write_word(XM_XR_DATA, 16'h0001);
    repeat (3) @(negedge clk);
    check(intr_count == count0 + 1, "pulse from a masked trigger");
    bus_read(XM_INT_CTRL, 1'b1, rd_byte);
    check(rd_byte[INTR_VIDEO], "masked trigger did not set status");

    // vsync interrupt cleared every frame like a handler would
    wait_vsync_rise(de_cycles, hs_cycles, pulses, intr_before);
    bus_write(XM_INT_CTRL, 1'b1, 8'h03);
    bus_write(XM_INT_CTRL, 1'b0, byte_t'(1 << INTR_VSYNC));
    for (int f = 0; f < 3; f++) begin
        wait_vsync_rise(de_cycles, hs_cycles, pulses, intr_before);
        check(pulses == 1 && intr_before, $sformatf("frame %0d: %0d pulses", f, pulses));
        check(de_cycles == H_VISIBLE * V_VISIBLE,
              $sformatf("frame %0d: %0d enable cycles", f, de_cycles));
        check(hs_cycles == H_SYNC * FRAME_LINES,
              $sformatf("frame %0d: %0d hsync cycles", f, hs_cycles));
        bus_write(XM_INT_CTRL, 1'b1, byte_t'(1 << INTR_VSYNC));
    end

    // palette and line 0 pixels
    for (int i = 0; i < 16; i++) begin
        write_word(XM_XR_ADDR, word_t'(XR_PALETTE + i));
        write_word(XM_XR_DATA, {4'h0, pal_data[i]});
    end
    write_word(XM_WR_ADDR, 16'h0000);
    for (int i = 0; i < LINE_WORDS; i++) write_word(XM_DATA, line_data[i]);
    check_first_line();

    $display("No errors");
    $finish;
end

endmodule

// File: vlog.f
common/xv_bus_pkg.sv
common/xv_video_pkg.sv
rtl/intr_ctrl.sv
rtl/vram_arb.sv
regs/reg_interface.sv
video/video_gen.sv
video/color_out.sv
rtl/xosera_main.sv
tb/xosera_tb.sv

// File: Makefile
SIM        = verilator
FLAGS      = --binary --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = xosera_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
